//--- common/cpu_pkg.sv
package cpu_pkg;

   localparam int WORD_W    = 32;
   localparam int REG_N     = 16;
   localparam int MEM_DEPTH = 1024;               // words, bus addresses wrap
   localparam int MEM_AW    = $clog2(MEM_DEPTH);

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [3:0]        reg_idx_t;
   typedef logic [MEM_AW-1:0] mem_addr_t;

   localparam reg_idx_t LINK_IDX = 4'd14;         // return address of CALL
   localparam reg_idx_t PC_IDX   = 4'd15;

   // instruction field positions
   localparam int COND_MSB = 31;
   localparam int COND_LSB = 28;
   localparam int OP_MSB   = 27;
   localparam int OP_LSB   = 25;
   localparam int RD_MSB   = 23;
   localparam int RD_LSB   = 20;
   localparam int RA_MSB   = 19;
   localparam int RA_LSB   = 16;
   localparam int RB_MSB   = 11;
   localparam int RB_LSB   = 8;
   localparam int FNR_MSB  = 3;                   // fn of ALU_R
   localparam int FNR_LSB  = 0;
   localparam int FNI_MSB  = 15;                  // fn of ALU_I
   localparam int FNI_LSB  = 12;
   localparam int IMM_MSB  = 11;                  // signed, lsb at 0
   localparam int OFF_MSB  = 15;                  // ld/st offset, signed
   localparam int TGT_MSB  = 23;                  // call target, unsigned

   // codes 3, 6 and 7 are executed as no-operations
   typedef enum logic [2:0] {
      OP_ALU_R = 3'd0,
      OP_ALU_I = 3'd1,
      OP_CALL  = 3'd2,
      OP_ST    = 3'd4,
      OP_LD    = 3'd5
   } opcode_e;

   typedef enum logic [3:0] {
      FN_MOV = 4'd0,
      FN_ADD = 4'd1,
      FN_SUB = 4'd2,
      FN_AND = 4'd3,
      FN_OR  = 4'd4,
      FN_XOR = 4'd5,
      FN_SHL = 4'd6,
      FN_SHR = 4'd7,
      FN_CMP = 4'd8                               // sub without writeback
   } alu_fn_e;

   typedef enum logic [3:0] {
      COND_AL, COND_EQ, COND_NE, COND_CS,
      COND_CC, COND_MI, COND_PL, COND_VS,
      COND_VC, COND_HI, COND_LS, COND_GE,
      COND_LT, COND_GT, COND_LE, COND_UNC
   } cond_e;

   typedef struct packed {
      logic c;
      logic z;
      logic s;
      logic v;
   } flags_t;

   // one-hot instruction phases
   typedef struct packed {
      logic f;
      logic e;
      logic m;
      logic w;
   } phase_t;

   typedef struct packed {
      word_t addr;                                // word address
      word_t wdata;
      logic  wen;
   } mem_bus_t;

endpackage

//--- cpu/phase_sched.sv
`timescale 1ns/1ps

module phase_sched import cpu_pkg::*;
(
   input  logic   clk,
   input  logic   rst_n_i,
   input  logic   run_i,
   output phase_t phase_o
);

   phase_t ring_q;

   // ring counter f -> e -> m -> w -> f
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         ring_q <= '{f: 1'b1, e: 1'b0, m: 1'b0, w: 1'b0};
      end
      else if (run_i)
      begin
         ring_q.f <= ring_q.w;
         ring_q.e <= ring_q.f;
         ring_q.m <= ring_q.e;
         ring_q.w <= ring_q.m;
      end
   end

   // strobes only act while running
   always_comb
   begin
      if (run_i)
      begin
         phase_o = ring_q;
      end
      else
      begin
         phase_o = '0;
      end
   end

endmodule

//--- cpu/reg_file.sv
`timescale 1ns/1ps

module reg_file import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n_i,
   input  reg_idx_t ra_i,
   input  reg_idx_t rb_i,
   input  reg_idx_t rd_i,
   input  reg_idx_t dbg_sel_i,
   input  logic     inc_pc_i,
   input  logic     link_i,
   input  logic     wb_en_i,
   input  reg_idx_t wb_idx_i,
   input  word_t    wb_data_i,
   output word_t    da_o,
   output word_t    db_o,
   output word_t    dd_o,
   output word_t    dbg_o,
   output word_t    pc_o
);

   word_t regs [REG_N];

   // later assignments win, so writeback beats the pc increment
   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         for (int i = 0; i < REG_N; i++)
         begin
            regs[i] <= '0;
         end
      end
      else
      begin
         if (inc_pc_i)
         begin
            regs[PC_IDX] <= regs[PC_IDX] + word_t'(1);
         end
         if (link_i)
         begin
            regs[LINK_IDX] <= regs[PC_IDX];   // pc already points past the call
         end
         if (wb_en_i)
         begin
            regs[wb_idx_i] <= wb_data_i;
         end
      end
   end

   assign da_o  = regs[ra_i];
   assign db_o  = regs[rb_i];
   assign dd_o  = regs[rd_i];      // store data
   assign dbg_o = regs[dbg_sel_i];
   assign pc_o  = regs[PC_IDX];

endmodule

//--- cpu/alu.sv
`timescale 1ns/1ps

module alu import cpu_pkg::*;
(
   input  alu_fn_e fn_i,
   input  word_t   a_i,
   input  word_t   b_i,
   input  flags_t  flags_i,
   output word_t   res_o,
   output flags_t  flags_o,
   output logic    wb_en_o
);

   logic [WORD_W:0] sum;            // carry in the top bit
   logic [WORD_W:0] diff;           // not-borrow in the top bit
   logic            add_ovf;
   logic            sub_ovf;

   assign sum  = {1'b0, a_i} + {1'b0, b_i};
   assign diff = {1'b0, a_i} + {1'b0, ~b_i} + 33'd1;

   // signed overflow, operand signs vs result sign
   assign add_ovf = (a_i[WORD_W-1] == b_i[WORD_W-1]) &&
                    (sum[WORD_W-1] != a_i[WORD_W-1]);
   assign sub_ovf = (a_i[WORD_W-1] != b_i[WORD_W-1]) &&
                    (diff[WORD_W-1] != a_i[WORD_W-1]);

   always_comb
   begin
      flags_o = flags_i;             // c and v kept unless arithmetic
      case (fn_i)
         FN_ADD:
         begin
            res_o     = sum[WORD_W-1:0];
            flags_o.c = sum[WORD_W];
            flags_o.v = add_ovf;
         end
         FN_SUB, FN_CMP:
         begin
            res_o     = diff[WORD_W-1:0];
            flags_o.c = diff[WORD_W];
            flags_o.v = sub_ovf;
         end
         FN_AND:  res_o = a_i & b_i;
         FN_OR:   res_o = a_i | b_i;
         FN_XOR:  res_o = a_i ^ b_i;
         FN_SHL:  res_o = a_i << b_i[4:0];
         FN_SHR:  res_o = a_i >> b_i[4:0];   // logical
         default: res_o = b_i;               // mov and unused codes
      endcase
      flags_o.z = (res_o == '0);
      flags_o.s = res_o[WORD_W-1];
   end

   assign wb_en_o = (fn_i != FN_CMP);

endmodule

//--- cpu/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n_i,
   input  phase_t   phase_i,
   input  word_t    rdata_i,
   input  reg_idx_t dbg_sel_i,
   output mem_bus_t bus_o,
   output word_t    dbg_o
);

   word_t    ir;                     // instruction register
   word_t    ld_data;                // load latch
   flags_t   flags_q;
   logic     exec_q;                 // condition result of current instr
   cond_e    cond;
   opcode_e  op;
   alu_fn_e  fn;
   reg_idx_t rd;
   reg_idx_t ra;
   reg_idx_t rb;
   logic     is_alu;
   logic     is_call;
   logic     is_ld;
   logic     is_st;
   word_t    da;
   word_t    db;
   word_t    dd;
   word_t    pc;
   word_t    imm;
   word_t    offset;
   word_t    target;
   word_t    alu_b;
   word_t    alu_res;
   flags_t   alu_flags;
   logic     alu_wb_en;
   word_t    ls_addr;
   logic     wb_en;
   reg_idx_t wb_idx;
   word_t    wb_data;

   function automatic logic cond_pass(input cond_e cc, input flags_t f);
      case (cc)
         COND_EQ: return f.z;
         COND_NE: return !f.z;
         COND_CS: return f.c;
         COND_CC: return !f.c;
         COND_MI: return f.s;
         COND_PL: return !f.s;
         COND_VS: return f.v;
         COND_VC: return !f.v;
         COND_HI: return f.c && !f.z;          // unsigned greater
         COND_LS: return !f.c || f.z;
         COND_GE: return f.s == f.v;
         COND_LT: return f.s != f.v;
         COND_GT: return !f.z && (f.s == f.v);
         COND_LE: return f.z || (f.s != f.v);
         default: return 1'b1;                 // always and uncond
      endcase
   endfunction

   // decode
   assign cond    = cond_e'(ir[COND_MSB:COND_LSB]);
   assign op      = opcode_e'(ir[OP_MSB:OP_LSB]);
   assign rd      = ir[RD_MSB:RD_LSB];
   assign ra      = ir[RA_MSB:RA_LSB];
   assign rb      = ir[RB_MSB:RB_LSB];
   assign is_alu  = (op == OP_ALU_R) || (op == OP_ALU_I);
   assign is_call = (op == OP_CALL);
   assign is_ld   = (op == OP_LD);
   assign is_st   = (op == OP_ST);
   assign fn      = (op == OP_ALU_I) ? alu_fn_e'(ir[FNI_MSB:FNI_LSB])
                                     : alu_fn_e'(ir[FNR_MSB:FNR_LSB]);

   assign imm     = {{(WORD_W-IMM_MSB-1){ir[IMM_MSB]}}, ir[IMM_MSB:0]};
   assign offset  = {{(WORD_W-OFF_MSB-1){ir[OFF_MSB]}}, ir[OFF_MSB:0]};
   assign target  = {{(WORD_W-TGT_MSB-1){1'b0}}, ir[TGT_MSB:0]};
   assign alu_b   = (op == OP_ALU_I) ? imm : db;
   assign ls_addr = da + offset;

   always_ff @(posedge clk)
   begin
      if (phase_i.f)
      begin
         ir <= rdata_i;
      end
      if (phase_i.m && exec_q && is_ld)
      begin
         ld_data <= rdata_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         exec_q  <= 1'b0;
         flags_q <= '0;
      end
      else
      begin
         if (phase_i.e)
         begin
            exec_q <= cond_pass(cond, flags_q);
         end
         if (phase_i.w && exec_q && is_alu)
         begin
            flags_q <= alu_flags;
         end
      end
   end

   // writeback select, call target goes to the pc
   assign wb_en   = phase_i.w && exec_q && ((is_alu && alu_wb_en) || is_ld || is_call);
   assign wb_idx  = is_call ? PC_IDX : rd;
   assign wb_data = is_call ? target : (is_ld ? ld_data : alu_res);

   reg_file u_reg_file (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .ra_i      (ra),
      .rb_i      (rb),
      .rd_i      (rd),
      .dbg_sel_i (dbg_sel_i),
      .inc_pc_i  (phase_i.e),
      .link_i    (phase_i.m && exec_q && is_call),
      .wb_en_i   (wb_en),
      .wb_idx_i  (wb_idx),
      .wb_data_i (wb_data),
      .da_o      (da),
      .db_o      (db),
      .dd_o      (dd),
      .dbg_o     (dbg_o),
      .pc_o      (pc)
   );

   alu u_alu (
      .fn_i    (fn),
      .a_i     (da),
      .b_i     (alu_b),
      .flags_i (flags_q),
      .res_o   (alu_res),
      .flags_o (alu_flags),
      .wb_en_o (alu_wb_en)
   );

   // bus shows the pc except in the memory phase of an executed ld/st
   assign bus_o.addr  = (phase_i.m && exec_q && (is_ld || is_st)) ? ls_addr : pc;
   assign bus_o.wdata = dd;
   assign bus_o.wen   = phase_i.m && exec_q && is_st;

endmodule

//--- logic/word_mem.sv
`timescale 1ns/1ps

module word_mem import cpu_pkg::*;
(
   input  logic      clk,
   input  mem_bus_t  bus_i,
   input  logic      load_en_i,
   input  mem_addr_t load_addr_i,
   input  word_t     load_data_i,
   output word_t     rdata_o
);

   word_t     mem [MEM_DEPTH];
   mem_addr_t bus_idx;

   // word addresses wrap at the memory depth
   assign bus_idx = bus_i.addr[MEM_AW-1:0];

   // program load takes the port over the core
   always_ff @(posedge clk)
   begin
      if (load_en_i)
      begin
         mem[load_addr_i] <= load_data_i;
      end
      else if (bus_i.wen)
      begin
         mem[bus_idx] <= bus_i.wdata;
      end
   end

   assign rdata_o = mem[bus_idx];   // same-cycle read

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ps

module cpu_top import cpu_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n_i,
   input  logic      run_i,
   input  logic      load_en_i,
   input  mem_addr_t load_addr_i,
   input  word_t     load_data_i,
   input  reg_idx_t  dbg_sel_i,
   output word_t     dbg_o,
   output mem_bus_t  mon_bus_o
);

   phase_t   phase;
   mem_bus_t bus;
   word_t    rdata;

   phase_sched u_phase_sched (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .run_i   (run_i),
      .phase_o (phase)
   );

   cpu_core u_cpu_core (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .phase_i   (phase),
      .rdata_i   (rdata),
      .dbg_sel_i (dbg_sel_i),
      .bus_o     (bus),
      .dbg_o     (dbg_o)
   );

   word_mem u_word_mem (
      .clk         (clk),
      .bus_i       (bus),
      .load_en_i   (load_en_i),
      .load_addr_i (load_addr_i),
      .load_data_i (load_data_i),
      .rdata_o     (rdata)
   );

   assign mon_bus_o = bus;   // bus monitor for the testbench

endmodule

//--- dv/cpu_props.sv
`timescale 1ns/1ps

module cpu_props import cpu_pkg::*;
(
   input logic     clk,
   input logic     rst_n_i,
   input phase_t   phase_i,
   input mem_bus_t bus_i
);

   // at most one strobe and none while stopped
   a_phase_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0(phase_i))
      else $error("phase strobes not one-hot: %b", phase_i);

   // f -> e -> m -> w -> f or all low once run drops
   a_phase_order: assert property (@(posedge clk) disable iff (!rst_n_i)
      (phase_i != '0) |=> (phase_i == '0) ||
         (phase_i == phase_t'({$past(phase_i.w), $past(phase_i.f),
                               $past(phase_i.e), $past(phase_i.m)})))
      else $error("phase strobes left their rotation order");

   a_wen_in_mem_phase: assert property (@(posedge clk) disable iff (!rst_n_i)
      bus_i.wen |-> phase_i.m)
      else $error("memory write outside the memory phase");

   // one write cycle per store
   a_wen_single: assert property (@(posedge clk) disable iff (!rst_n_i)
      bus_i.wen |=> !bus_i.wen)
      else $error("memory write held for two cycles");

endmodule

//--- dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

   localparam int HALT_ADDR = 119;   // last program word
   localparam int DATA_BASE = 768;   // r0 base in the middle of the data region

   logic      clk;
   logic      rst_n_i;
   logic      run_i;
   logic      load_en_i;
   mem_addr_t load_addr_i;
   word_t     load_data_i;
   reg_idx_t  dbg_sel_i;
   word_t     dbg_o;
   mem_bus_t  mon_bus_o;

   word_t  image [MEM_DEPTH];        // memory contents at load time
   word_t  model_mem [MEM_DEPTH];
   word_t  model_regs [REG_N];
   flags_t model_flags;
   word_t  exp_st_addr [$];
   word_t  exp_st_data [$];
   int     n_instr;
   int     n_checks = 0;
   int     n_errors = 0;
   int     watchdog_cycles = 0;

   cpu_top UUT (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .run_i       (run_i),
      .load_en_i   (load_en_i),
      .load_addr_i (load_addr_i),
      .load_data_i (load_data_i),
      .dbg_sel_i   (dbg_sel_i),
      .dbg_o       (dbg_o),
      .mon_bus_o   (mon_bus_o)
   );

   bind cpu_core cpu_props u_cpu_props (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .phase_i (phase_i),
      .bus_i   (bus_o)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   task automatic check_val(input string name, input word_t got, input word_t exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   // data words differ across the whole address
   function automatic word_t fill_word(input int a);
      return 32'hC3A5_0000 ^ (word_t'(a) * 32'h9E37_79B1);
   endfunction

   function automatic word_t random_instr();
      logic [3:0]  cc;
      logic [3:0]  fn;
      logic [3:0]  rd;
      logic [3:0]  ra;
      logic [3:0]  rb;
      logic [15:0] off;
      cc  = 4'($urandom_range(0, 15));
      fn  = 4'($urandom_range(0, 8));
      rd  = 4'($urandom_range(1, 13));   // r0 keeps the data base
      ra  = 4'($urandom_range(0, 15));
      rb  = 4'($urandom_range(0, 15));
      off = 16'($urandom_range(0, 511) - 256);
      case ($urandom_range(0, 9))
         0, 1, 2: return {cc, OP_ALU_R, 1'b0, rd, ra, 4'd0, rb, 4'd0, fn};
         3, 4, 5: return {cc, OP_ALU_I, 1'b0, rd, ra, fn, 12'($urandom())};
         6:       return {cc, OP_LD, 1'b0, rd, 4'd0, off};
         7:       return {cc, OP_ST, 1'b0, rb, 4'd0, off};   // any register as data
         8:       return {cc, 3'd3, 25'($urandom())};
         default: return {cc, 3'(6 + $urandom_range(0, 1)), 25'($urandom())};
      endcase
   endfunction

   task automatic build_program();
      logic [3:0] cc;
      for (int a = 0; a < MEM_DEPTH; a++)
      begin
         image[a] = fill_word(a);
      end
      image[0] = {4'd0, OP_ALU_I, 1'b0, 4'd0, 4'd0, 4'd0, 12'(DATA_BASE)};  // mov r0
      for (int i = 1; i < HALT_ADDR; i++)
      begin
         cc = ($urandom_range(0, 1) == 0) ? 4'd0 : 4'($urandom_range(0, 15));
         if (i % 15 == 0)
         begin
            image[i] = {cc, OP_CALL, 1'b0, 24'(i + $urandom_range(2, 4))};
         end
         else
         begin
            image[i] = random_instr();
         end
      end
      image[HALT_ADDR] = {4'd0, OP_CALL, 1'b0, 24'(HALT_ADDR)};   // jump to self
   endtask

   function automatic logic cond_holds(input logic [3:0] cc, input flags_t f);
      case (cc)
         4'd1:    return f.z;
         4'd2:    return !f.z;
         4'd3:    return f.c;
         4'd4:    return !f.c;
         4'd5:    return f.s;
         4'd6:    return !f.s;
         4'd7:    return f.v;
         4'd8:    return !f.v;
         4'd9:    return f.c && !f.z;
         4'd10:   return !f.c || f.z;
         4'd11:   return f.s == f.v;
         4'd12:   return f.s != f.v;
         4'd13:   return !f.z && (f.s == f.v);
         4'd14:   return f.z || (f.s != f.v);
         default: return 1'b1;
      endcase
   endfunction

   function automatic word_t alu_model(input logic [3:0] fn, input word_t a, input word_t b,
                                       input flags_t f_in, output flags_t f_out);
      word_t              r;
      logic signed [32:0] wide;
      f_out = f_in;
      case (fn)
         FN_ADD:
         begin
            r         = a + b;
            wide      = $signed({a[31], a}) + $signed({b[31], b});
            f_out.c   = (r < a);                   // sum wrapped past 2**32
            f_out.v   = (wide[32] != wide[31]);    // true sum outside the signed range
         end
         FN_SUB, FN_CMP:
         begin
            r         = a - b;
            wide      = $signed({a[31], a}) - $signed({b[31], b});
            f_out.c   = (a >= b);                  // no borrow
            f_out.v   = (wide[32] != wide[31]);
         end
         FN_AND:  r = a & b;
         FN_OR:   r = a | b;
         FN_XOR:  r = a ^ b;
         FN_SHL:  r = a << b[4:0];
         FN_SHR:  r = a >> b[4:0];
         default: r = b;
      endcase
      f_out.z = (r == '0);
      f_out.s = r[31];
      return r;
   endfunction

   task automatic run_model();
      word_t      pc;
      word_t      ins;
      word_t      addr;
      word_t      b;
      word_t      res;
      flags_t     nf;
      logic [3:0] rd;
      logic [3:0] ra;
      logic [3:0] fn;
      logic [2:0] op;
      for (int a = 0; a < MEM_DEPTH; a++)
      begin
         model_mem[a] = image[a];
      end
      model_regs  = '{default: '0};
      model_flags = '0;
      pc          = '0;
      n_instr     = 0;
      while (n_instr < 4000)
      begin
         ins = model_mem[pc[MEM_AW-1:0]];
         op  = ins[OP_MSB:OP_LSB];
         rd  = ins[RD_MSB:RD_LSB];
         ra  = ins[RA_MSB:RA_LSB];
         n_instr++;
         model_regs[PC_IDX] = pc + 1;   // pc moves on before operands are read
         addr = model_regs[ra] + {{16{ins[OFF_MSB]}}, ins[OFF_MSB:0]};
         if (cond_holds(ins[COND_MSB:COND_LSB], model_flags))
         begin
            case (op)
               OP_ALU_R, OP_ALU_I:
               begin
                  fn = (op == OP_ALU_I) ? ins[FNI_MSB:FNI_LSB] : ins[FNR_MSB:FNR_LSB];
                  b  = (op == OP_ALU_I) ? {{20{ins[IMM_MSB]}}, ins[IMM_MSB:0]}
                                        : model_regs[ins[RB_MSB:RB_LSB]];
                  res = alu_model(fn, model_regs[ra], b, model_flags, nf);
                  model_flags = nf;
                  if (fn != FN_CMP)
                  begin
                     model_regs[rd] = res;
                  end
               end
               OP_CALL:
               begin
                  model_regs[LINK_IDX] = model_regs[PC_IDX];
                  model_regs[PC_IDX]   = {8'd0, ins[TGT_MSB:0]};
               end
               OP_ST:
               begin
                  exp_st_addr.push_back(addr);
                  exp_st_data.push_back(model_regs[rd]);
                  model_mem[addr[MEM_AW-1:0]] = model_regs[rd];
               end
               OP_LD:   model_regs[rd] = model_mem[addr[MEM_AW-1:0]];
               default: ;                     // no-operation codes
            endcase
         end
         if (pc == word_t'(HALT_ADDR))
         begin
            break;
         end
         pc = model_regs[PC_IDX];
      end
   endtask

   task automatic read_reg(input reg_idx_t idx, output word_t val);
      @(posedge clk);
      dbg_sel_i <= idx;
      @(posedge clk);
      val = dbg_o;
   endtask

   task automatic wait_pc(input word_t target);
      do
      begin
         @(posedge clk);
      end
      while (dbg_o !== target);
   endtask

   // every write must match the next predicted store
   always @(posedge clk)
   begin
      if (mon_bus_o.wen)
      begin
         if (!run_i)
         begin
            n_errors++;
            $display("memory write at %0t while the core was stopped", $time);
         end
         else if (exp_st_addr.size() == 0)
         begin
            n_errors++;
            $display("unexpected store at %0t to address %h", $time, mon_bus_o.addr);
         end
         else
         begin
            check_val("mon_bus_o.addr", mon_bus_o.addr, exp_st_addr.pop_front());
            check_val("mon_bus_o.wdata", mon_bus_o.wdata, exp_st_data.pop_front());
         end
      end
   end

   initial
   begin
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, halt loop not reached", watchdog_cycles);
      $display("FAIL: see errors above");
      $finish;
   end

   initial
   begin
      word_t got;
      void'($urandom(71));
      rst_n_i     = 1'b0;
      run_i       = 1'b0;
      load_en_i   = 1'b0;
      load_addr_i = '0;
      load_data_i = '0;
      dbg_sel_i   = '0;
      build_program();
      run_model();
      watchdog_cycles = 16 + MEM_DEPTH + 8 * REG_N + 4 * n_instr + 100;
      repeat (16) @(posedge clk);
      rst_n_i <= 1'b1;
      for (int a = 0; a < MEM_DEPTH; a++)
      begin
         load_en_i   <= 1'b1;
         load_addr_i <= mem_addr_t'(a);
         load_data_i <= image[a];
         @(posedge clk);
      end
      load_en_i <= 1'b0;
      for (int i = 0; i < REG_N; i++)
      begin
         read_reg(reg_idx_t'(i), got);
         check_val($sformatf("r%0d before run", i), got, '0);
      end
      @(posedge clk);
      dbg_sel_i <= PC_IDX;
      run_i     <= 1'b1;
      wait_pc(word_t'(HALT_ADDR + 1));   // halt call passed execute
      wait_pc(word_t'(HALT_ADDR));       // and wrote its target back
      run_i <= 1'b0;
      for (int i = 0; i < REG_N; i++)
      begin
         read_reg(reg_idx_t'(i), got);
         check_val($sformatf("r%0d", i), got, model_regs[i]);
      end
      if (exp_st_addr.size() != 0)
      begin
         n_errors++;
         $display("%0d predicted stores never appeared on the bus", exp_st_addr.size());
      end
      $display("%0d instructions, %0d checks, %0d errors", n_instr, n_checks, n_errors);
      if (n_errors == 0)
      begin
         $display("PASS: all tests");
      end
      else
      begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

//--- verilog.f
common/cpu_pkg.sv
cpu/phase_sched.sv
cpu/reg_file.sv
cpu/alu.sv
cpu/cpu_core.sv
logic/word_mem.sv
logic/cpu_top.sv
dv/cpu_props.sv
dv/cpu_tb.sv

//--- run.sh
#!/bin/sh
# build the cpu testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module cpu_tb -f verilog.f -o cpu_sim \
   || { echo "build failed"; exit 1; }
out=$(./obj_dir/cpu_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "PASS: all tests" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
